// ==== src/dcache_pkg.sv ====
package dcache_pkg;

	// ========================================
	// geometry.
	// ========================================
	localparam int s_offset = 5;
	localparam int s_index = 3;
	localparam int s_tag = 32 - s_offset - s_index;
	localparam int num_sets = 2**s_index;
	localparam int line_bits = 8 * (2**s_offset);
	localparam int words_per_line = line_bits / 32;

	typedef logic [line_bits-1:0] line_t;

	// one entry per set per way.
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [s_tag-1:0] tag;
	} cache_meta_t;

	// request as latched from the cpu port.
	typedef struct packed {
		logic [31:0] address;
		logic write;
		logic [31:0] wdata;
		logic [3:0] byte_en;
	} cache_req_t;

	// memory address source.
	typedef enum logic [1:0] {
		fill_addr = 2'd0, // line of the current request.
		victim_addr = 2'd1 // victim tag with the request index.
	} pmem_sel_t;

endpackage

// ==== src/dcache_ctl_if.sv ====
`timescale 1ns/1ns

interface dcache_ctl_if import dcache_pkg::*; ();

	// strobes from the FSM.
	logic capture;
	logic lookup;
	logic write_hit;
	logic fill;
	logic touch_lru;
	pmem_sel_t addr_sel;

	// status from the datapath.
	logic hit;
	logic victim_dirty;
	logic req_write;

	modport ctl (
		output capture, lookup, write_hit, fill, touch_lru, addr_sel,
		input hit, victim_dirty, req_write
	);

	modport dp (
		input capture, lookup, write_hit, fill, touch_lru, addr_sel,
		output hit, victim_dirty, req_write
	);

endinterface

// ==== src/dcache_array.sv ====
`timescale 1ns/1ns

module dcache_array import dcache_pkg::*; #(
	parameter type payload_t = line_t
) (
	input logic clk,
	input logic rst_n,
	input logic read,
	input logic [s_index-1:0] rindex,
	input logic load,
	input logic [s_index-1:0] windex,
	input payload_t datain,
	output payload_t dataout
);

	payload_t entries [num_sets];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sets; i++) begin
				entries[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (load) begin
				entries[windex] <= datain;
			end
			if (read) begin
				dataout <= entries[rindex]; // old value when windex == rindex.
			end
		end
	end

	a_windex_known: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> !$isunknown(windex))
		else $error("dcache_array write index unknown.");

endmodule

// ==== src/dcache_bus_adapter.sv ====
`timescale 1ns/1ns

module dcache_bus_adapter import dcache_pkg::*; (
	input line_t line_in,
	input logic [s_offset-1:0] offset,
	input logic [31:0] wdata,
	input logic [3:0] byte_en,
	output logic [31:0] word_out,
	output line_t line_out
);

	logic [$clog2(words_per_line)-1:0] word_idx;

	assign word_idx = offset[s_offset-1:2]; // accesses are aligned so the byte bits drop out.
	assign word_out = line_in[32*word_idx +: 32];

	// replace only the enabled bytes of the addressed word.
	always_comb begin
		line_out = line_in;
		for (int b = 0; b < 4; b++) begin
			if (byte_en[b]) begin
				line_out[32*word_idx + 8*b +: 8] = wdata[8*b +: 8];
			end
		end
	end

endmodule

// ==== src/dcache_dp.sv ====
`timescale 1ns/1ns

module dcache_dp import dcache_pkg::*; (
	input logic clk,
	input logic rst_n,
	dcache_ctl_if.dp ctl,
	input logic [31:0] cpu_addr,
	input logic cpu_write,
	input logic [31:0] cpu_wdata,
	input logic [3:0] cpu_byte_en,
	output logic [31:0] cpu_rdata,
	input line_t mem_rdata,
	output logic [31:0] mem_addr,
	output line_t mem_wdata
);

	cache_req_t req;
	cache_meta_t meta_out [2];
	cache_meta_t meta_in;
	line_t data_out [2];
	line_t data_in;
	line_t line_sel;
	line_t line_merged;
	logic [31:0] word_sel;
	logic [1:0] way_hit;
	logic [1:0] way_load;
	logic hit_way;
	logic victim;
	logic accessed;
	logic [num_sets-1:0] lru; // names the least recently used way of each set.
	logic [s_tag-1:0] req_tag;
	logic [s_index-1:0] req_index;

	assign req_tag = req.address[31 -: s_tag];
	assign req_index = req.address[s_offset +: s_index];

	always_ff @(posedge clk) begin
		if (ctl.capture) begin
			req <= '{address: cpu_addr, write: cpu_write, wdata: cpu_wdata, byte_en: cpu_byte_en};
		end
	end

	// ========================================
	// ways.
	// ========================================
	for (genvar w = 0; w < 2; w++) begin : g_way
		dcache_array #(.payload_t(cache_meta_t)) i_meta (
			.clk(clk),
			.rst_n(rst_n),
			.read(ctl.lookup),
			.rindex(req_index),
			.load(way_load[w]),
			.windex(req_index),
			.datain(meta_in),
			.dataout(meta_out[w])
		);

		dcache_array #(.payload_t(line_t)) i_data (
			.clk(clk),
			.rst_n(rst_n),
			.read(ctl.lookup),
			.rindex(req_index),
			.load(way_load[w]),
			.windex(req_index),
			.datain(data_in),
			.dataout(data_out[w])
		);

		assign way_hit[w] = meta_out[w].valid && (meta_out[w].tag == req_tag);
		assign way_load[w] = (ctl.write_hit && (hit_way == 1'(w))) ||
			(ctl.fill && (victim == 1'(w)));
	end

	assign hit_way = way_hit[1];
	assign victim = lru[req_index];
	assign ctl.hit = |way_hit;
	assign ctl.victim_dirty = meta_out[victim].valid && meta_out[victim].dirty;
	assign ctl.req_write = req.write;

	// ========================================
	// line merge and write data.
	// ========================================
	assign line_sel = ctl.fill ? mem_rdata : data_out[hit_way];

	dcache_bus_adapter i_bus_adapter (
		.line_in(line_sel),
		.offset(req.address[s_offset-1:0]),
		.wdata(req.wdata),
		.byte_en(req.byte_en),
		.word_out(word_sel),
		.line_out(line_merged)
	);

	assign data_in = req.write ? line_merged : mem_rdata;
	assign meta_in = '{valid: 1'b1, dirty: req.write, tag: req_tag}; // a write leaves it dirty.

	// ========================================
	// LRU and read data.
	// ========================================
	assign accessed = ctl.fill ? victim : hit_way;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru <= '0;
		end else if (ctl.touch_lru) begin
			lru[req_index] <= ~accessed;
		end
	end

	always_ff @(posedge clk) begin
		if (ctl.touch_lru) begin
			cpu_rdata <= word_sel; // held through the ack phase.
		end
	end

	// memory side.
	always_comb begin
		unique case (ctl.addr_sel)
			victim_addr: mem_addr = {meta_out[victim].tag, req_index, {s_offset{1'b0}}};
			default: mem_addr = {req.address[31:s_offset], {s_offset{1'b0}}};
		endcase
	end

	assign mem_wdata = data_out[victim];

	a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
		!(way_hit[0] && way_hit[1]))
		else $error("both ways hit in set %0d.", req_index);

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*; (
	input logic clk,
	input logic rst_n,
	dcache_ctl_if.ctl ctl,
	input logic cpu_req,
	output logic cpu_ack,
	output logic cpu_miss,
	output logic mem_req,
	input logic mem_ack,
	output logic mem_write
);

	typedef enum logic [2:0] {
		idle,
		lookup,
		compare,
		wb_req,
		wb_done,
		fill_req,
		fill_done,
		respond
	} state_t;

	state_t state;
	state_t state_next;
	logic ack_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cpu_ack <= 1'b0;
			cpu_miss <= 1'b0;
		end else begin
			state <= state_next;
			cpu_ack <= ack_next;
			if (ctl.capture) begin
				cpu_miss <= 1'b0;
			end else if (state == compare && !ctl.hit) begin
				cpu_miss <= 1'b1;
			end
		end
	end

	// ========================================
	// next state and strobes.
	// ========================================
	always_comb begin
		state_next = state;
		ack_next = cpu_ack;
		ctl.capture = 1'b0;
		ctl.lookup = 1'b0;
		ctl.write_hit = 1'b0;
		ctl.fill = 1'b0;
		ctl.touch_lru = 1'b0;
		ctl.addr_sel = fill_addr;
		mem_req = 1'b0;
		mem_write = 1'b0;

		unique case (state)
			idle: begin
				if (cpu_req) begin
					ctl.capture = 1'b1;
					state_next = lookup;
				end
			end
			lookup: begin
				ctl.lookup = 1'b1; // arrays valid in compare.
				state_next = compare;
			end
			compare: begin
				if (ctl.hit) begin
					ctl.touch_lru = 1'b1;
					ctl.write_hit = ctl.req_write;
					state_next = respond;
				end else if (ctl.victim_dirty) begin
					state_next = wb_req;
				end else begin
					state_next = fill_req;
				end
			end
			wb_req: begin
				mem_req = 1'b1;
				mem_write = 1'b1;
				ctl.addr_sel = victim_addr;
				if (mem_ack) begin
					state_next = wb_done;
				end
			end
			wb_done: begin
				ctl.addr_sel = victim_addr;
				if (!mem_ack) begin
					state_next = fill_req;
				end
			end
			fill_req: begin
				mem_req = 1'b1;
				if (mem_ack) begin
					ctl.fill = 1'b1; // mem_rdata is valid now.
					ctl.touch_lru = 1'b1;
					state_next = fill_done;
				end
			end
			fill_done: begin
				if (!mem_ack) begin
					state_next = respond;
				end
			end
			respond: begin
				if (!cpu_ack) begin
					ack_next = 1'b1;
				end else if (!cpu_req) begin
					ack_next = 1'b0;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	a_mem_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req raised while mem_ack still high.");

	a_cpu_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_ack) |-> cpu_req)
		else $error("cpu_ack raised without cpu_req.");

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; (
	input logic clk,
	input logic rst_n,
	// cpu port.
	input logic cpu_req,
	output logic cpu_ack,
	input logic [31:0] cpu_addr,
	input logic cpu_write,
	input logic [31:0] cpu_wdata,
	input logic [3:0] cpu_byte_en,
	output logic [31:0] cpu_rdata,
	output logic cpu_miss,
	// memory port.
	output logic mem_req,
	input logic mem_ack,
	output logic mem_write,
	output logic [31:0] mem_addr,
	output line_t mem_wdata,
	input line_t mem_rdata
);

	dcache_ctl_if ctl ();

	dcache_ctrl i_dcache_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl.ctl),
		.cpu_req(cpu_req),
		.cpu_ack(cpu_ack),
		.cpu_miss(cpu_miss),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.mem_write(mem_write)
	);

	dcache_dp i_dcache_dp (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl.dp),
		.cpu_addr(cpu_addr),
		.cpu_write(cpu_write),
		.cpu_wdata(cpu_wdata),
		.cpu_byte_en(cpu_byte_en),
		.cpu_rdata(cpu_rdata),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb import dcache_pkg::*; ();

	typedef struct packed {
		logic op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] byte_en;
		logic [31:0] rdata;
		logic miss;
	} access_t;

	logic clk;
	logic rst_n;
	logic cpu_req;
	logic cpu_ack;
	logic [31:0] cpu_addr;
	logic cpu_write;
	logic [31:0] cpu_wdata;
	logic [3:0] cpu_byte_en;
	logic [31:0] cpu_rdata;
	logic cpu_miss;
	logic mem_req;
	logic mem_ack;
	logic mem_write;
	logic [31:0] mem_addr;
	line_t mem_wdata;
	line_t mem_rdata;

	access_t accesses [$];
	line_t mem_lines [logic [31:0]];
	logic [31:0] recent [num_sets]; // most recently used line of each set.
	logic [31:0] older [num_sets];
	bit dirty_lines [logic [31:0]];
	logic [31:0] wb_expect [$];
	logic [31:0] wb_seen [$];
	logic [31:0] cur_line;
	logic [31:0] lcg_state = 32'h9128_bf74;
	int errors = 0;
	int mem_errors = 0;
	int mem_req_rises = 0;
	int cycles = 0;
	int cycle_limit = 1000;

	tb_clock i_tb_clock (.clk(clk));

	dcache_top i_dcache_top (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// an untouched word at address a reads as a ^ 32'h5a5a_0000.
	function automatic line_t initial_line(input logic [31:0] base);
		line_t l;
		for (int i = 0; i < words_per_line; i++) begin
			l[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	// the older of the two lines in a set is evicted on a miss.
	task automatic predict_eviction(input logic [31:0] line, input logic write);
		logic [s_index-1:0] set;
		set = line[s_offset +: s_index];
		if (line == older[set]) begin
			older[set] = recent[set];
			recent[set] = line;
		end else if (line != recent[set]) begin
			if (dirty_lines.exists(older[set])) begin
				wb_expect.push_back(older[set]);
				dirty_lines.delete(older[set]);
			end
			older[set] = recent[set];
			recent[set] = line;
		end
		if (write) begin
			dirty_lines[line] = 1'b1;
		end
	endtask

	task automatic load_stimulus();
		int fd;
		string text;
		logic [31:0] f [6];
		fd = $fopen("tests/dcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/dcache_stimulus.txt");
			errors++;
			return;
		end
		while ($fgets(text, fd) != 0) begin
			if (text.len() > 1 && text[0] != "#") begin
				if ($sscanf(text, "%h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
					accesses.push_back('{op: f[0][0], addr: f[1], wdata: f[2],
						byte_en: f[3][3:0], rdata: f[4], miss: f[5][0]});
				end else begin
					$display("stimulus line could not be parsed: %s", text);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	// ========================================
	// cpu side.
	// ========================================
	task automatic run_access(input access_t a);
		int edges;
		cur_line = {a.addr[31:s_offset], {s_offset{1'b0}}};
		predict_eviction(cur_line, a.op);
		cpu_addr <= a.addr;
		cpu_write <= a.op;
		cpu_wdata <= a.wdata;
		cpu_byte_en <= a.byte_en;
		cpu_req <= 1'b1;
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
		end while (!cpu_ack);
		// req is first sampled one edge in and ack is seen one edge after it rose.
		if (!a.miss && edges - 2 != 3) begin
			$display("FAIL cpu_ack latency at %h: expected %h, got %h", a.addr, 3, edges - 2);
			errors++;
		end
		if (cpu_miss != a.miss) begin
			$display("FAIL cpu_miss at %h: expected %h, got %h", a.addr, a.miss, cpu_miss);
			errors++;
		end
		if (!a.op && cpu_rdata != a.rdata) begin
			$display("FAIL cpu_rdata at %h: expected %h, got %h", a.addr, a.rdata, cpu_rdata);
			errors++;
		end
		cpu_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (cpu_ack);
	endtask

	initial begin : main
		int misses;
		rst_n <= 1'b0;
		cpu_req <= 1'b0;
		cpu_addr <= '0;
		cpu_write <= 1'b0;
		cpu_wdata <= '0;
		cpu_byte_en <= '0;
		misses = 0;
		foreach (recent[s]) begin
			recent[s] = '1; // all ones is never a line address.
			older[s] = '1;
		end
		load_stimulus();
		if (accesses.size() == 0) begin
			$display("the stimulus file holds no accesses");
			errors++;
		end
		cycle_limit = 200 * (accesses.size() + 1);
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		foreach (accesses[i]) begin
			if (accesses[i].miss) begin
				misses++;
			end
			run_access(accesses[i]);
		end
		if (wb_seen.size() != wb_expect.size()) begin
			$display("FAIL mem_write count: expected %h, got %h",
				wb_expect.size(), wb_seen.size());
			errors++;
		end else begin
			foreach (wb_expect[i]) begin
				if (wb_seen[i] != wb_expect[i]) begin
					$display("FAIL mem_addr write-back: expected %h, got %h",
						wb_expect[i], wb_seen[i]);
					errors++;
				end
			end
		end
		if (mem_req_rises != misses + wb_expect.size()) begin
			$display("FAIL mem_req rises: expected %h, got %h", misses + wb_expect.size(),
				mem_req_rises);
			errors++;
		end
		$display("%0d accesses, %0d errors", accesses.size(), errors + mem_errors);
		if (errors + mem_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// ========================================
	// memory side.
	// ========================================
	initial begin : memory_model
		logic [31:0] addr;
		logic [31:0] rnd;
		mem_ack <= 1'b0;
		mem_rdata <= '0;
		forever begin
			@(posedge clk);
			if (mem_req) begin
				mem_req_rises++;
				addr = mem_addr;
				rnd = lcg_next();
				repeat (1 + int'(rnd[17:16])) @(posedge clk); // 1 to 4 cycles.
				if (mem_write) begin
					wb_seen.push_back(addr);
					mem_lines[addr] = mem_wdata;
				end else begin
					if (addr != cur_line) begin
						$display("FAIL mem_addr fill: expected %h, got %h", cur_line, addr);
						mem_errors++;
					end
					mem_rdata <= mem_lines.exists(addr) ? mem_lines[addr] : initial_line(addr);
				end
				mem_ack <= 1'b1;
				do begin
					@(posedge clk);
				end while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("tests failed");
			$finish;
		end
	end

endmodule

// ==== build.f ====
src/dcache_pkg.sv
src/dcache_ctl_if.sv
src/dcache_array.sv
src/dcache_bus_adapter.sv
src/dcache_dp.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_clock.sv
tests/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = dcache_tb
FILELIST = build.f
PASS_MSG = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tests/dcache_stimulus.txt ====
# columns: op addr wdata byte_en exp_rdata exp_miss, all in hex.
# op 0 is a read and 1 a write; exp_rdata is not checked on writes.
0 00010024 00000000 0 5a5b0024 1
0 00010024 00000000 0 5a5b0024 0
1 00010028 11223344 5 00000000 0
0 00010028 00000000 0 5a220044 0
0 00020020 00000000 0 5a580020 1
0 00010024 00000000 0 5a5b0024 0
0 00030020 00000000 0 5a590020 1
0 00010028 00000000 0 5a220044 0
0 00020024 00000000 0 5a580024 1
0 00030030 00000000 0 5a590030 1
0 00010028 00000000 0 5a220044 1
0 00010024 00000000 0 5a5b0024 0
1 0004004c deadbeef c 00000000 1
0 0004004c 00000000 0 dead004c 0
0 00040040 00000000 0 5a5e0040 0
1 00040044 cafef00d f 00000000 0
0 00050040 00000000 0 5a5f0040 1
0 00060048 00000000 0 5a5c0048 1
0 00040044 00000000 0 cafef00d 1
0 0004004c 00000000 0 dead004c 0
1 abcd01fc 00000077 1 00000000 1
0 abcd01fc 00000000 0 f1970177 0
